// File: hdl/cp0RegPkg.sv
// Register numbers assume select 0 only; unlisted numbers are unmapped and read as zero
package cp0RegPkg;

    parameter int DataWidth = 32;
    parameter int HwIntNum  = 6;

    // CP0 register numbers as seen on the bus address
    typedef enum logic [4:0] {
        regBadVAddr = 5'd8,
        regCount    = 5'd9,
        regCompare  = 5'd11,
        regStatus   = 5'd12,
        regCause    = 5'd13,
        regEpc      = 5'd14
    } cp0RegE;

    // Status fields
    parameter int StatusIeBit  = 0;
    parameter int StatusExlBit = 1;
    parameter int StatusImLo   = 8;
    parameter int StatusImHi   = 15;

    // Cause fields
    parameter int CauseExcLo  = 2;
    parameter int CauseExcHi  = 6;
    parameter int CauseSwIpLo = 8;
    parameter int CauseSwIpHi = 9;
    parameter int CauseHwIpLo = 10;
    parameter int CauseHwIpHi = 15;
    parameter int CauseTiBit  = 30;
    parameter int CauseBdBit  = 31;

endpackage

// File: hdl/cp0ExcPkg.sv
// Exception kinds without TLB, coprocessor-unusable or refetch; excNone means no event
package cp0ExcPkg;

    // Exception kinds reported by the pipeline
    typedef enum logic [3:0] {
        excNone      = 4'd0,
        excInt       = 4'd1,
        excAdelFetch = 4'd2,  // Bad fetch address
        excAdelData  = 4'd3,  // Bad load address
        excAdes      = 4'd4,
        excRi        = 4'd5,
        excSys       = 4'd6,
        excBp        = 4'd7,
        excTrap      = 4'd8,
        excOv        = 4'd9,
        excEret      = 4'd10
    } excTypeE;

    // Architectural ExcCode values
    typedef enum logic [4:0] {
        codeInt  = 5'd0,
        codeAdel = 5'd4,
        codeAdes = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRi   = 5'd10,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCodeE;

    function automatic excCodeE excCodeOf(excTypeE kind);
        case (kind)
            excAdelFetch, excAdelData: return codeAdel;
            excAdes:                   return codeAdes;
            excRi:                     return codeRi;
            excSys:                    return codeSys;
            excBp:                     return codeBp;
            excTrap:                   return codeTr;
            excOv:                     return codeOv;
            default:                   return codeInt;
        endcase
    endfunction

endpackage

// File: hdl/cp0BusSlave.sv
// No wait states and no error ack; the master must hold its request until wbAck
`timescale 1ns/10ps

module cp0BusSlave (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              wbCyc,
    input  logic                              wbStb,
    input  logic                              wbWe,
    input  logic [4:0]                        wbAdr,
    input  logic [cp0RegPkg::DataWidth-1:0]   wbDatW,
    input  logic [31:0]                       count,
    input  logic [31:0]                       compare,
    input  logic [31:0]                       status,
    input  logic [31:0]                       cause,
    input  logic [31:0]                       epc,
    input  logic [31:0]                       badVAddr,
    output logic [cp0RegPkg::DataWidth-1:0]   wbDatR,
    output logic                              wbAck,
    output logic                              wrCount,
    output logic                              wrCompare,
    output logic                              wrStatus,
    output logic                              wrCause,
    output logic                              wrEpc,
    output logic [31:0]                       wrData
);

    import cp0RegPkg::*;

    typedef enum logic {
        sIdle,
        sAck
    } busStateE;

    busStateE             state;
    cp0RegE               regSel;
    logic                 accept;
    logic                 doWrite;
    logic [DataWidth-1:0] readMux;

    assign regSel  = cp0RegE'(wbAdr);
    assign accept  = (state == sIdle) && wbCyc && wbStb;
    assign doWrite = accept && wbWe;

    // One-cycle strobes at the sampling edge
    assign wrCount   = doWrite && (regSel == regCount);
    assign wrCompare = doWrite && (regSel == regCompare);
    assign wrStatus  = doWrite && (regSel == regStatus);
    assign wrCause   = doWrite && (regSel == regCause);
    assign wrEpc     = doWrite && (regSel == regEpc);
    assign wrData    = wbDatW;

    assign wbAck = (state == sAck);

    always_comb begin
        case (regSel)
            regBadVAddr: readMux = badVAddr;
            regCount:    readMux = count;
            regCompare:  readMux = compare;
            regStatus:   readMux = status;
            regCause:    readMux = cause;
            regEpc:      readMux = epc;
            default:     readMux = '0;  // Unmapped
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
        end else if (accept) begin
            state <= sAck;
        end else if (state == sAck) begin
            state <= sIdle;
        end
    end

    // Read data lines up with wbAck
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbDatR <= '0;
        end else if (accept) begin
            wbDatR <= wbWe ? '0 : readMux;
        end
    end

endmodule

// File: hdl/cp0Timer.sv
// Count advances every countDiv clocks (countDiv >= 1); Count writes restart the prescaler
`timescale 1ns/10ps

module cp0Timer #(
    parameter int countDiv = 2
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wrCount,
    input  logic        wrCompare,
    input  logic [31:0] wrData,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timerMatch,
    output logic        timerPending
);

    localparam int PreW = (countDiv > 1) ? $clog2(countDiv) : 1;

    logic [PreW-1:0] preCnt;
    logic            countEn;
    logic            matchQ;

    assign countEn    = (preCnt == PreW'(countDiv - 1));
    assign timerMatch = (count == compare);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            preCnt <= '0;
        end else if (wrCount || countEn) begin
            preCnt <= '0;
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count   <= '0;
            compare <= '0;
        end else begin
            if (wrCount) begin
                count <= wrData;
            end else if (countEn) begin
                count <= count + 32'd1;
            end
            if (wrCompare) compare <= wrData;
        end
    end

    // Pends on a new match, Compare write acknowledges
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            matchQ       <= 1'b1;  // Reset state 0 == 0 is not a match event
            timerPending <= 1'b0;
        end else begin
            matchQ <= timerMatch;
            if (wrCompare) begin
                timerPending <= 1'b0;
            end else if (timerMatch && !matchQ) begin
                timerPending <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/cp0ExcRegs.sv
// Exceptions win over bus writes to the same field; no BEV, CE or TLB exceptions
`timescale 1ns/10ps

module cp0ExcRegs (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            wrStatus,
    input  logic                            wrCause,
    input  logic                            wrEpc,
    input  logic [31:0]                     wrData,
    input  logic [cp0RegPkg::HwIntNum-1:0]  hwInt,
    input  logic                            timerMatch,
    input  logic                            timerPending,
    input  cp0ExcPkg::excTypeE              excType,
    input  logic [31:0]                     excPc,
    input  logic [31:0]                     excBadAddr,
    input  logic                            excInDelaySlot,
    output logic [31:0]                     status,
    output logic [31:0]                     cause,
    output logic [31:0]                     epc,
    output logic [31:0]                     badVAddr,
    output logic                            irq,
    output logic                            statusExl
);

    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    logic [7:0]          im;
    logic                exl;
    logic                ie;
    logic                bd;
    excCodeE             excCode;
    logic [HwIntNum-1:0] ipHw;
    logic [1:0]          ipSw;
    logic                isExc;
    logic [7:0]          ipAll;

    assign isExc = (excType != excNone) && (excType != excEret);
    assign ipAll = {ipHw, ipSw};

    assign irq       = ie && !exl && |(im & ipAll);
    assign statusExl = exl;

    always_comb begin
        status                        = '0;
        status[StatusImHi:StatusImLo] = im;
        status[StatusExlBit]          = exl;
        status[StatusIeBit]           = ie;
    end

    always_comb begin
        cause                           = '0;
        cause[CauseBdBit]               = bd;
        cause[CauseTiBit]               = timerPending;
        cause[CauseHwIpHi:CauseHwIpLo]  = ipHw;
        cause[CauseSwIpHi:CauseSwIpLo]  = ipSw;
        cause[CauseExcHi:CauseExcLo]    = excCode;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            im  <= '0;
            ie  <= 1'b0;
            exl <= 1'b0;
        end else begin
            if (wrStatus) begin
                im <= wrData[StatusImHi:StatusImLo];
                ie <= wrData[StatusIeBit];
            end
            if (isExc) begin
                exl <= 1'b1;
            end else if (excType == excEret) begin
                exl <= 1'b0;
            end else if (wrStatus) begin
                exl <= wrData[StatusExlBit];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bd      <= 1'b0;
            excCode <= codeInt;
            ipHw    <= '0;
            ipSw    <= '0;
        end else begin
            ipHw <= hwInt | {timerMatch, {(HwIntNum - 1){1'b0}}};  // Timer on IP7
            if (wrCause) ipSw <= wrData[CauseSwIpHi:CauseSwIpLo];
            if (isExc) begin
                excCode <= excCodeOf(excType);
                if (!exl) bd <= excInDelaySlot;
            end
        end
    end

    // EPC holds the first faulting pc while EXL is set
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            epc <= '0;
        end else if (isExc && !exl) begin
            epc <= excInDelaySlot ? excPc - 32'd4 : excPc;
        end else if (wrEpc) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            badVAddr <= '0;
        end else if (excType == excAdelFetch) begin
            badVAddr <= excPc;
        end else if (excType == excAdelData || excType == excAdes) begin
            badVAddr <= excBadAddr;
        end
    end

endmodule

// File: hdl/cp0Top.sv
// Single Wishbone classic slave, one access per two cycles; countDiv must be 1 or more
`timescale 1ns/10ps

module cp0Top #(
    parameter int countDiv = 2
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              wbCyc,
    input  logic                              wbStb,
    input  logic                              wbWe,
    input  logic [4:0]                        wbAdr,
    input  logic [cp0RegPkg::DataWidth-1:0]   wbDatW,
    output logic [cp0RegPkg::DataWidth-1:0]   wbDatR,
    output logic                              wbAck,
    input  logic [cp0RegPkg::HwIntNum-1:0]    hwInt,
    input  cp0ExcPkg::excTypeE                excType,
    input  logic [31:0]                       excPc,
    input  logic [31:0]                       excBadAddr,
    input  logic                              excInDelaySlot,
    output logic                              irq,
    output logic                              statusExl,
    output logic [31:0]                       epc
);

    logic        wrCount;
    logic        wrCompare;
    logic        wrStatus;
    logic        wrCause;
    logic        wrEpc;
    logic [31:0] wrData;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] badVAddr;
    logic        timerMatch;
    logic        timerPending;

    cp0BusSlave u_cp0BusSlave (
        .clk      (clk),
        .arstN    (arstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .count    (count),
        .compare  (compare),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badVAddr (badVAddr),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck),
        .wrCount  (wrCount),
        .wrCompare(wrCompare),
        .wrStatus (wrStatus),
        .wrCause  (wrCause),
        .wrEpc    (wrEpc),
        .wrData   (wrData)
    );

    cp0Timer #(
        .countDiv(countDiv)
    ) u_cp0Timer (
        .clk         (clk),
        .arstN       (arstN),
        .wrCount     (wrCount),
        .wrCompare   (wrCompare),
        .wrData      (wrData),
        .count       (count),
        .compare     (compare),
        .timerMatch  (timerMatch),
        .timerPending(timerPending)
    );

    cp0ExcRegs u_cp0ExcRegs (
        .clk           (clk),
        .arstN         (arstN),
        .wrStatus      (wrStatus),
        .wrCause       (wrCause),
        .wrEpc         (wrEpc),
        .wrData        (wrData),
        .hwInt         (hwInt),
        .timerMatch    (timerMatch),
        .timerPending  (timerPending),
        .excType       (excType),
        .excPc         (excPc),
        .excBadAddr    (excBadAddr),
        .excInDelaySlot(excInDelaySlot),
        .status        (status),
        .cause         (cause),
        .epc           (epc),
        .badVAddr      (badVAddr),
        .irq           (irq),
        .statusExl     (statusExl)
    );

endmodule

// File: test/cp0Tb.sv
// Directed tests assume countDiv 2 and falling-edge inputs; timer checks are cycle exact
`timescale 1ns/10ps

module cp0Tb;

    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    localparam int CountDiv      = 2;
    localparam int AckLimit      = 4;
    localparam int TimeoutCycles = 2000;  // Whole run needs well under 400 cycles

    logic          clk;
    logic          arstN;
    logic          wbCyc;
    logic          wbStb;
    logic          wbWe;
    logic [4:0]    wbAdr;
    logic [31:0]   wbDatW;
    logic [31:0]   wbDatR;
    logic          wbAck;
    logic [5:0]    hwInt;
    excTypeE       excType;
    logic [31:0]   excPc;
    logic [31:0]   excBadAddr;
    logic          excInDelaySlot;
    logic          irq;
    logic          statusExl;
    logic [31:0]   epc;

    int            errCount;
    int            checkCount;
    int            cycleCnt;

    cp0Top #(
        .countDiv(CountDiv)
    ) u_cp0Top (
        .clk           (clk),
        .arstN         (arstN),
        .wbCyc         (wbCyc),
        .wbStb         (wbStb),
        .wbWe          (wbWe),
        .wbAdr         (wbAdr),
        .wbDatW        (wbDatW),
        .wbDatR        (wbDatR),
        .wbAck         (wbAck),
        .hwInt         (hwInt),
        .excType       (excType),
        .excPc         (excPc),
        .excBadAddr    (excBadAddr),
        .excInDelaySlot(excInDelaySlot),
        .irq           (irq),
        .statusExl     (statusExl),
        .epc           (epc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compareVal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("[ERROR] at time %0t: %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    // One Wishbone classic cycle started right after a falling edge
    task automatic busXfer(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
        int waited;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = wdata;
        @(negedge clk);
        waited = 1;
        while (!wbAck && waited < AckLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!wbAck) begin
            errCount++;
            $display("Bus access to register %0d got no wbAck within %0d cycles", adr, AckLimit);
        end else if (waited != 1) begin
            errCount++;
            $display("wbAck for register %0d came after %0d cycles instead of 1", adr, waited);
        end
        rdata = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge clk);  // Slave passes through Ack
    endtask

    task automatic wbWrite(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        busXfer(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input logic [4:0] adr, output logic [31:0] data);
        busXfer(1'b0, adr, 32'h0, data);
    endtask

    // Exception port event for one cycle
    task automatic raiseExc(input excTypeE kind, input logic [31:0] pc, input logic [31:0] bad,
                            input logic inSlot);
        excType        = kind;
        excPc          = pc;
        excBadAddr     = bad;
        excInDelaySlot = inSlot;
        @(negedge clk);
        excType        = excNone;
        excInDelaySlot = 1'b0;
    endtask

    task automatic resetAndAccess();
        logic [31:0] rd;
        wbRead(regCount, rd);  // Fewer than countDiv cycles since reset
        compareVal(rd, 32'h0, "Count after reset");
        wbRead(regStatus, rd);
        compareVal(rd, 32'h0, "Status after reset");
        wbRead(regCause, rd);
        compareVal(rd, 32'h0, "Cause after reset");
        wbRead(regEpc, rd);
        compareVal(rd, 32'h0, "EPC after reset");
        wbRead(regCompare, rd);
        compareVal(rd, 32'h0, "Compare after reset");
        wbRead(regBadVAddr, rd);
        compareVal(rd, 32'h0, "BadVAddr after reset");
        compareVal(32'(irq), 32'h0, "irq after reset");
        compareVal(32'(statusExl), 32'h0, "statusExl after reset");
        wbWrite(regStatus, 32'hFFFF_FFFF);
        wbRead(regStatus, rd);
        compareVal(rd, 32'h0000_FF03, "Status keeps IM, EXL and IE only");
        compareVal(32'(statusExl), 32'h1, "statusExl from Status write");
        wbWrite(regEpc, 32'h1234_5678);
        wbRead(regEpc, rd);
        compareVal(rd, 32'h1234_5678, "EPC readback");
        wbWrite(regCompare, 32'hA5A5_0F0F);
        wbRead(regCompare, rd);
        compareVal(rd, 32'hA5A5_0F0F, "Compare readback");
        wbWrite(regBadVAddr, 32'hFFFF_FFFF);
        wbRead(regBadVAddr, rd);
        compareVal(rd, 32'h0, "BadVAddr is read-only");
        wbRead(5'd3, rd);
        compareVal(rd, 32'h0, "Unmapped register");
        wbWrite(regStatus, 32'h0);
    endtask

    task automatic excEntryEret();
        logic [31:0] rd;
        raiseExc(excSys, 32'h8000_0200, 32'h0, 1'b0);
        compareVal(32'(statusExl), 32'h1, "statusExl after syscall");
        compareVal(epc, 32'h8000_0200, "epc port after syscall");
        wbRead(regEpc, rd);
        compareVal(rd, 32'h8000_0200, "EPC after syscall");
        wbRead(regCause, rd);
        compareVal(32'(rd[6:2]), 32'd8, "ExcCode for syscall");
        compareVal(32'(rd[31]), 32'h0, "BD for syscall");
        // Nested while EXL is set
        raiseExc(excOv, 32'h8000_0300, 32'h0, 1'b0);
        wbRead(regEpc, rd);
        compareVal(rd, 32'h8000_0200, "EPC held under EXL");
        wbRead(regCause, rd);
        compareVal(32'(rd[6:2]), 32'd12, "ExcCode for overflow");
        raiseExc(excEret, 32'h0, 32'h0, 1'b0);
        compareVal(32'(statusExl), 32'h0, "statusExl after ERET");
        raiseExc(excBp, 32'h8000_0404, 32'h0, 1'b1);
        wbRead(regEpc, rd);
        compareVal(rd, 32'h8000_0400, "EPC for delay-slot breakpoint");
        wbRead(regCause, rd);
        compareVal(32'(rd[31]), 32'h1, "BD for delay-slot breakpoint");
        compareVal(32'(rd[6:2]), 32'd9, "ExcCode for breakpoint");
    endtask

    task automatic badVAddrCapture();
        logic [31:0] rd;
        raiseExc(excAdelFetch, 32'hBFC0_0011, 32'h0, 1'b0);
        wbRead(regBadVAddr, rd);
        compareVal(rd, 32'hBFC0_0011, "BadVAddr from fetch pc");
        wbRead(regCause, rd);
        compareVal(32'(rd[6:2]), 32'd4, "ExcCode for fetch address error");
        raiseExc(excAdes, 32'h8000_0480, 32'h1000_0003, 1'b0);
        wbRead(regBadVAddr, rd);
        compareVal(rd, 32'h1000_0003, "BadVAddr from store address");
        wbRead(regCause, rd);
        compareVal(32'(rd[6:2]), 32'd5, "ExcCode for store address error");
        raiseExc(excRi, 32'h8000_0500, 32'hDEAD_BEEF, 1'b0);
        wbRead(regBadVAddr, rd);
        compareVal(rd, 32'h1000_0003, "BadVAddr kept on reserved instruction");
        wbRead(regCause, rd);
        compareVal(32'(rd[6:2]), 32'd10, "ExcCode for reserved instruction");
        raiseExc(excEret, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic timerInterrupt();
        logic [31:0] rd;
        logic        inRange;
        wbWrite(regCount, 32'h0000_1000);
        repeat (24) @(negedge clk);
        wbRead(regCount, rd);
        inRange = (rd >= 32'h0000_100A) && (rd <= 32'h0000_1014);
        compareVal(32'(inRange), 32'h1, "Count advance after 24 idle cycles");
        wbWrite(regStatus, 32'h0000_8001);  // IM7 and IE
        wbWrite(regCompare, 32'h0000_2005);
        wbWrite(regCount, 32'h0000_2000);
        // Count hits Compare 10 cycles after the write edge
        repeat (10) @(negedge clk);
        compareVal(32'(irq), 32'h1, "irq from timer on IP7");
        wbRead(regCause, rd);
        compareVal(32'(rd[30]), 32'h1, "Cause TI on match");
        compareVal(32'(rd[15]), 32'h1, "Cause IP7 on match");
        repeat (30) @(negedge clk);
        wbRead(regCause, rd);
        compareVal(32'(rd[30]), 32'h1, "Cause TI stays pending");
        wbWrite(regCompare, 32'h0);
        wbRead(regCause, rd);
        compareVal(32'(rd[30]), 32'h0, "Cause TI cleared by Compare write");
        wbWrite(regStatus, 32'h0);
    endtask

    task automatic interruptMasking();
        logic [31:0] rd;
        logic [31:0] stList [4];
        logic        irqList [4];
        stList  = '{32'h0000_1001, 32'h0000_1000, 32'h0000_1003, 32'h0000_0801};
        irqList = '{1'b1, 1'b0, 1'b0, 1'b0};  // Only IM4 with IE and no EXL fires
        hwInt = 6'b000100;
        @(negedge clk);
        wbRead(regCause, rd);
        compareVal(32'(rd[12]), 32'h1, "Cause IP4 from hwInt[2]");
        foreach (stList[i]) begin
            wbWrite(regStatus, stList[i]);
            compareVal(32'(irq), 32'(irqList[i]), "irq for hardware line 2");
        end
        hwInt = 6'b000000;
        repeat (2) @(negedge clk);
        wbWrite(regStatus, 32'h0000_0101);
        wbWrite(regCause, 32'h0000_0100);
        compareVal(32'(irq), 32'h1, "irq for software IP0");
        wbWrite(regCause, 32'h0000_0200);
        compareVal(32'(irq), 32'h0, "irq for masked IP1");
        wbWrite(regStatus, 32'h0000_0201);
        compareVal(32'(irq), 32'h1, "irq for software IP1");
        wbWrite(regCause, 32'h0);
        wbWrite(regStatus, 32'h0);
        compareVal(32'(irq), 32'h0, "irq with nothing pending");
    endtask

    initial begin
        errCount       = 0;
        checkCount     = 0;
        arstN          = 1'b0;
        wbCyc          = 1'b0;
        wbStb          = 1'b0;
        wbWe           = 1'b0;
        wbAdr          = 5'd0;
        wbDatW         = 32'h0;
        hwInt          = 6'b0;
        excType        = excNone;
        excPc          = 32'h0;
        excBadAddr     = 32'h0;
        excInDelaySlot = 1'b0;
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        resetAndAccess();
        excEntryEret();
        badVAddrCapture();
        timerInterrupt();
        interruptMasking();
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycleCnt = 0;
        while (cycleCnt < TimeoutCycles) begin
            @(posedge clk);
            cycleCnt++;
        end
        $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: mipsCp0.f
hdl/cp0RegPkg.sv
hdl/cp0ExcPkg.sv
hdl/cp0BusSlave.sv
hdl/cp0Timer.sv
hdl/cp0ExcRegs.sv
hdl/cp0Top.sv
test/cp0Tb.sv

// File: Makefile
# Verilator build and run for the mipsCp0 testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f mipsCp0.f --top-module cp0Tb -o cp0Tb

run: compile
	./obj_dir/cp0Tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
